// ==== Bender.yml ====
package:
  name: sd_link

sources:
  - hw/sd_link_pkg.sv
  - hw/spi_msg_decode.sv
  - hw/spi_cmd_execute.sv
  - hw/cmd6_mode_capture.sv
  - hw/spi_resp_shift.sv
  - hw/sd_link_top.sv
  - target: test
    files:
      - bench/sd_link_tb.sv

// ==== bench/sd_link_tb.sv ====
`default_nettype none

module sd_link_tb;

    localparam int clk_half    = 20;
    localparam int drive_delay = 2;
    localparam int turnaround  = sd_link_pkg::default_turnaround;
    localparam int cmd6_word   = sd_link_pkg::default_cmd6_word;
    localparam int resp_len    = sd_link_pkg::resp_len;
    localparam int max_rows    = 16;
    localparam int max_words   = 16;   // Longest block in the table plus its start pulse

    logic        sd_datInWrite_clk;
    logic        sd_datInWrite_rst_;
    logic        spi_data_in;
    logic        dat_block_start;
    logic        dat_trigger;
    logic [15:0] dat_data;
    logic        spi_data_out;
    logic        spi_data_oe;
    logic [3:0]  leds;

    // Stimulus and expected values, one entry per row
    string       row_name  [max_rows];
    bit          row_block [max_rows];
    int          row_words [max_rows];
    logic [15:0] row_word8 [max_rows];
    logic [63:0] row_msg   [max_rows];
    bit          row_resp  [max_rows];
    logic [63:0] row_expect[max_rows];
    logic [3:0]  row_leds  [max_rows];
    int          n_rows;

    // Reference model state while the table is built
    logic [3:0]  led_model;
    logic [3:0]  mode_model;
    logic        captured_model;

    logic [31:0] lcg_state;
    int          err_count;
    int          check_count;
    int          cycle_count;
    int          cycle_limit = 100000;

    sd_link_top UUT (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .spi_data_in        (spi_data_in),
        .dat_block_start    (dat_block_start),
        .dat_trigger        (dat_trigger),
        .dat_data           (dat_data),
        .spi_data_out       (spi_data_out),
        .spi_data_oe        (spi_data_oe),
        .leds               (leds)
    );

    initial begin
        sd_datInWrite_clk = 1'b0;
        forever #(clk_half) sd_datInWrite_clk = ~sd_datInWrite_clk;
    end

    always @(posedge sd_datInWrite_clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run still busy after %0d clock cycles", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [55:0] lcg_arg();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi[31:8], lo};
    endfunction

    // Filler words keep bits 11..8 away from the captured values
    function automatic logic [15:0] fill_word(input int idx);
        return 16'(idx * 16'h1013 + 16'h0E05);
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("** Error: %s is %h, expected %h", name, got, exp);
            err_count++;
        end
    endtask

    // Appends a row and works out its expected outcome
    task automatic add_row(input string name, input bit blk, input int words,
                           input logic [15:0] w8, input logic [7:0] mtype,
                           input logic [55:0] arg);
        row_name[n_rows]   = name;
        row_block[n_rows]  = blk;
        row_words[n_rows]  = words;
        row_word8[n_rows]  = w8;
        row_msg[n_rows]    = {mtype, arg};
        row_resp[n_rows]   = 1'b0;
        row_expect[n_rows] = '0;
        if (blk) begin
            captured_model = (words > cmd6_word);
            if (captured_model) begin
                mode_model = w8[11:8];
            end
        end
        case (mtype)
            8'h80: begin
                row_resp[n_rows]   = 1'b1;
                row_expect[n_rows] = {8'h00, arg};
            end
            8'h82: begin
                row_resp[n_rows]   = 1'b1;
                row_expect[n_rows] = {59'd0, captured_model, mode_model};
            end
            8'h01: led_model = arg[3:0];
            default: ;
        endcase
        row_leds[n_rows] = led_model;
        n_rows++;
    endtask

    task automatic feed_block(input int words, input logic [15:0] w8);
        int i;
        @(posedge sd_datInWrite_clk);
        #(drive_delay);
        dat_block_start = 1'b1;
        @(posedge sd_datInWrite_clk);
        #(drive_delay);
        dat_block_start = 1'b0;
        for (i = 0; i < words; i++) begin
            dat_trigger = 1'b1;
            dat_data    = (i == cmd6_word) ? w8 : fill_word(i);
            @(posedge sd_datInWrite_clk);
            #(drive_delay);
        end
        dat_trigger = 1'b0;
        dat_data    = '0;
    endtask

    // Start bit, then 64 bits MSB first
    task automatic send_msg(input logic [63:0] msg);
        int b;
        @(posedge sd_datInWrite_clk);
        #(drive_delay);
        spi_data_in = 1'b1;
        for (b = 63; b >= 0; b--) begin
            @(posedge sd_datInWrite_clk);
            #(drive_delay);
            spi_data_in = msg[b];
        end
        @(posedge sd_datInWrite_clk);
        #(drive_delay);
        spi_data_in = 1'b0;
    endtask

    task automatic collect_response(output logic [63:0] word, output int high_cycles,
                                    output int gap, output bit seen);
        int wait_cnt;
        word        = '0;
        high_cycles = 0;
        gap         = 0;
        seen        = 1'b0;
        wait_cnt    = 0;
        while (!seen && wait_cnt < turnaround + 20) begin
            @(posedge sd_datInWrite_clk);
            #(drive_delay);
            if (spi_data_oe) begin
                seen = 1'b1;
            end else begin
                gap++;
            end
            wait_cnt++;
        end
        // Bounded so a stuck enable cannot hold the loop
        while (seen && spi_data_oe && high_cycles < resp_len + 8) begin
            word = {word[62:0], spi_data_out};
            high_cycles++;
            @(posedge sd_datInWrite_clk);
            #(drive_delay);
        end
    endtask

    task automatic expect_silence(input int cycles);
        int  i;
        bit  rose;
        rose = 1'b0;
        for (i = 0; i < cycles; i++) begin
            @(posedge sd_datInWrite_clk);
            #(drive_delay);
            if (spi_data_oe && !rose) begin
                $display("spi_data_oe went high where no response was due");
                err_count++;
                rose = 1'b1;
            end
        end
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        logic [63:0] word;
        int          high_cycles;
        int          gap;
        bit          seen;
        int          r;
        int          errs_before;

        sd_datInWrite_rst_ = 1'b0;
        spi_data_in        = 1'b0;
        dat_block_start    = 1'b0;
        dat_trigger        = 1'b0;
        dat_data           = '0;
        lcg_state          = 32'd56;
        err_count          = 0;
        check_count        = 0;
        cycle_count        = 0;
        n_rows             = 0;
        led_model          = '0;
        mode_model         = '0;
        captured_model     = 1'b0;

        add_row("echo 1",            0, 0,  16'h0000, 8'h80, lcg_arg());
        add_row("echo 2",            0, 0,  16'h0000, 8'h80, lcg_arg());
        add_row("led set",           0, 0,  16'h0000, 8'h01, 56'h5A_0000_0000_00A5);
        add_row("nop",               0, 0,  16'h0000, 8'h00, 56'h00_0000_0000_000C);
        add_row("status, full blk",  1, 12, 16'hB3C7, 8'h82, 56'd0);
        add_row("status, short blk", 1, 4,  16'h0000, 8'h82, 56'd0);
        add_row("type 7f",           0, 0,  16'h0000, 8'h7F, 56'h00_0000_0000_0003);
        add_row("type c3",           0, 0,  16'h0000, 8'hC3, 56'h00_0000_0000_0009);
        add_row("echo after bad",    0, 0,  16'h0000, 8'h80, lcg_arg());
        add_row("led set 2",         0, 0,  16'h0000, 8'h01, 56'h00_0000_0000_123A);
        add_row("echo 3",            0, 0,  16'h0000, 8'h80, lcg_arg());

        cycle_limit = n_rows * (65 + turnaround + resp_len + max_words + 20) + 60;

        repeat (3) @(posedge sd_datInWrite_clk);
        #(drive_delay);
        sd_datInWrite_rst_ = 1'b1;

        // Idle line after reset
        errs_before = err_count;
        check_value("leds", 64'(leds), 64'h0);
        expect_silence(20);
        $display("reset idle: %s", (err_count == errs_before) ? "ok" : "FAILED");

        for (r = 0; r < n_rows; r++) begin
            errs_before = err_count;
            if (row_block[r]) begin
                feed_block(row_words[r], row_word8[r]);
            end
            send_msg(row_msg[r]);
            if (row_resp[r]) begin
                collect_response(word, high_cycles, gap, seen);
                if (!seen) begin
                    $display("No response: spi_data_oe never went high in row %0d", r);
                    err_count++;
                end else begin
                    check_value("spi_data_out", word, row_expect[r]);
                    check_value("spi_data_oe cycles", 64'(high_cycles), 64'(resp_len));
                    if (gap < turnaround) begin
                        $display("Turnaround too short: %0d cycles in row %0d", gap, r);
                        err_count++;
                    end
                end
            end else begin
                expect_silence(turnaround + resp_len + 10);
            end
            check_value("leds", 64'(leds), 64'(row_leds[r]));
            repeat (3) @(posedge sd_datInWrite_clk);
            $display("row %0d %s: %s", r, row_name[r],
                     (err_count == errs_before) ? "ok" : "FAILED");
        end

        $display("Rows: %0d, checks: %0d, errors: %0d", n_rows, check_count, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/cmd6_mode_capture.sv ====
`default_nettype none

module cmd6_mode_capture #(
    parameter int cmd6_word_index = sd_link_pkg::default_cmd6_word
) (
    input  logic                              sd_datInWrite_clk,
    input  logic                              sd_datInWrite_rst_,
    input  logic                              dat_block_start,
    input  logic                              dat_trigger,
    input  logic [sd_link_pkg::dat_width-1:0] dat_data,
    output logic [3:0]                        access_mode,
    output logic                              mode_captured
);

    // Counter only has to reach the target index
    localparam int cnt_width = (cmd6_word_index > 0) ? $clog2(cmd6_word_index + 1) : 1;
    localparam logic [cnt_width-1:0] target = cnt_width'(cmd6_word_index);

    logic [cnt_width-1:0] word_cnt;
    logic                 armed;    // Still looking for the word in this block

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            word_cnt      <= '0;
            armed         <= 1'b0;
            access_mode   <= '0;
            mode_captured <= 1'b0;
        end else if (dat_block_start) begin
            word_cnt      <= '0;
            armed         <= 1'b1;
            mode_captured <= 1'b0;
        end else if (dat_trigger && armed) begin
            if (word_cnt == target) begin
                access_mode   <= dat_data[sd_link_pkg::access_mode_lsb +: 4];
                mode_captured <= 1'b1;
                armed         <= 1'b0;  // Rest of the block is ignored
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/sd_link_pkg.sv ====
`default_nettype none

package sd_link_pkg;

    // ======================================================================
    // Serial message and response framing
    // ======================================================================

    // Bits after the start bit, MSB first
    localparam int msg_len  = 64;

    // Type field sits in the top bits, argument below it
    localparam int type_len = 8;
    localparam int arg_len  = 56;

    // Response shifted back out after the turnaround gap
    localparam int resp_len = 64;

    // Message types
    // Anything unlisted decodes to MSG_BAD
    typedef enum logic [type_len-1:0] {
        MSG_NOP         = 8'h00,
        MSG_LED_SET     = 8'h01,
        MSG_ECHO        = 8'h80,  // Responds
        MSG_CMD6_STATUS = 8'h82,  // Responds
        MSG_BAD         = 8'hff
    } msg_type_e;

    // ======================================================================
    // LEDs and SD data-in stream
    // ======================================================================

    localparam int led_width       = 4;    // Low argument bits
    localparam int dat_width       = 16;   // SD data-in word

    // CMD6 access mode lives in bits 11..8 of the captured word
    localparam int access_mode_lsb = 8;

    // ======================================================================
    // Defaults for the top-level parameters
    // ======================================================================

    // Idle cycles between resp_load and the first response bit
    localparam int default_turnaround = 8;

    // Word index within a block, counted from 0 after block start
    localparam int default_cmd6_word  = 8;

endpackage

`default_nettype wire

// ==== hw/sd_link_top.sv ====
`default_nettype none

module sd_link_top #(
    parameter int turnaround_cycles = sd_link_pkg::default_turnaround,
    parameter int cmd6_word_index   = sd_link_pkg::default_cmd6_word
) (
    input  logic                              sd_datInWrite_clk,
    input  logic                              sd_datInWrite_rst_,
    input  logic                              spi_data_in,
    input  logic                              dat_block_start,
    input  logic                              dat_trigger,
    input  logic [sd_link_pkg::dat_width-1:0] dat_data,
    output logic                              spi_data_out,
    output logic                              spi_data_oe,
    output logic [sd_link_pkg::led_width-1:0] leds
);

    // Decode to execute
    logic                             msg_valid;
    sd_link_pkg::msg_type_e           msg_type;
    logic [sd_link_pkg::arg_len-1:0]  msg_arg;

    // Execute to shifter
    logic                             resp_load;
    logic [sd_link_pkg::resp_len-1:0] resp_word;
    logic                             resp_busy;    // Holds the decoder

    // Capture to execute
    logic [3:0]                       access_mode;
    logic                             mode_captured;

    // ======================================================================
    // Command path
    // ======================================================================

    spi_msg_decode u_decode (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .spi_data_in        (spi_data_in),
        .resp_busy          (resp_busy),
        .msg_valid          (msg_valid),
        .msg_type           (msg_type),
        .msg_arg            (msg_arg)
    );

    spi_cmd_execute u_execute (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .msg_valid          (msg_valid),
        .msg_type           (msg_type),
        .msg_arg            (msg_arg),
        .access_mode        (access_mode),
        .mode_captured      (mode_captured),
        .leds               (leds),
        .resp_load          (resp_load),
        .resp_word          (resp_word)
    );

    spi_resp_shift #(
        .turnaround_cycles  (turnaround_cycles)
    ) u_shift (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .resp_load          (resp_load),
        .resp_word          (resp_word),
        .spi_data_out       (spi_data_out),
        .spi_data_oe        (spi_data_oe),
        .resp_busy          (resp_busy)
    );

    // ======================================================================
    // SD data-in side
    // ======================================================================

    cmd6_mode_capture #(
        .cmd6_word_index    (cmd6_word_index)
    ) u_capture (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .dat_block_start    (dat_block_start),
        .dat_trigger        (dat_trigger),
        .dat_data           (dat_data),
        .access_mode        (access_mode),
        .mode_captured      (mode_captured)
    );

endmodule

`default_nettype wire

// ==== hw/spi_cmd_execute.sv ====
`default_nettype none

module spi_cmd_execute (
    input  logic                              sd_datInWrite_clk,
    input  logic                              sd_datInWrite_rst_,
    input  logic                              msg_valid,
    input  sd_link_pkg::msg_type_e            msg_type,
    input  logic [sd_link_pkg::arg_len-1:0]   msg_arg,
    input  logic [3:0]                        access_mode,
    input  logic                              mode_captured,
    output logic [sd_link_pkg::led_width-1:0] leds,
    output logic                              resp_load,
    output logic [sd_link_pkg::resp_len-1:0]  resp_word
);

    // Captured flag plus 4 access-mode bits
    localparam int status_bits = 5;

    logic [sd_link_pkg::resp_len-1:0] echo_word;
    logic [sd_link_pkg::resp_len-1:0] status_word;
    logic [sd_link_pkg::resp_len-1:0] resp_next;
    logic                             resp_hit;
    logic                             led_hit;

    // ======================================================================
    // Response words
    // ======================================================================

    // Argument in the low bits, top byte zero
    assign echo_word = {{(sd_link_pkg::resp_len - sd_link_pkg::arg_len){1'b0}}, msg_arg};

    assign status_word = {{(sd_link_pkg::resp_len - status_bits){1'b0}},
                          mode_captured, access_mode};

    always_comb begin
        resp_hit  = 1'b0;
        led_hit   = 1'b0;
        resp_next = echo_word;

        case (msg_type)
            sd_link_pkg::MSG_ECHO: begin
                resp_hit = 1'b1;
            end
            sd_link_pkg::MSG_CMD6_STATUS: begin
                resp_hit  = 1'b1;
                resp_next = status_word;
            end
            sd_link_pkg::MSG_LED_SET: begin
                led_hit = 1'b1;
            end
            default: begin
                // Nop and unknown types fall through quietly
                resp_hit = 1'b0;
            end
        endcase
    end

    // ======================================================================
    // Registers
    // ======================================================================

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            leds      <= '0;
            resp_load <= 1'b0;
        end else begin
            resp_load <= msg_valid && resp_hit;  // One-cycle strobe
            if (msg_valid && led_hit) begin
                leds <= msg_arg[sd_link_pkg::led_width-1:0];
            end
        end
    end

    // Response payload, valid alongside resp_load
    always_ff @(posedge sd_datInWrite_clk) begin
        if (msg_valid && resp_hit) begin
            resp_word <= resp_next;
        end
    end

endmodule

`default_nettype wire

// ==== hw/spi_msg_decode.sv ====
`default_nettype none

module spi_msg_decode (
    input  logic                            sd_datInWrite_clk,
    input  logic                            sd_datInWrite_rst_,
    input  logic                            spi_data_in,
    input  logic                            resp_busy,
    output logic                            msg_valid,
    output sd_link_pkg::msg_type_e          msg_type,
    output logic [sd_link_pkg::arg_len-1:0] msg_arg
);

    localparam int cnt_width = $clog2(sd_link_pkg::msg_len);
    localparam logic [cnt_width-1:0] last_bit = cnt_width'(sd_link_pkg::msg_len - 1);

    // Cycles spent in wait before looking at resp_busy
    // Covers execute latency plus the shifter taking resp_load
    localparam int gap_cycles = 2;
    localparam logic [cnt_width-1:0] gap_last = cnt_width'(gap_cycles - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_WAIT,
        ST_HOLD
    } state_e;

    state_e                             state;
    logic [cnt_width-1:0]               bit_cnt;
    logic [sd_link_pkg::msg_len-1:0]    msg_reg;
    logic [sd_link_pkg::type_len-1:0]   type_field;

    // ======================================================================
    // Field extraction and type decode
    // ======================================================================

    assign type_field = msg_reg[sd_link_pkg::msg_len-1 -: sd_link_pkg::type_len];
    assign msg_arg    = msg_reg[sd_link_pkg::arg_len-1:0];

    always_comb begin
        case (type_field)
            sd_link_pkg::MSG_NOP:         msg_type = sd_link_pkg::MSG_NOP;
            sd_link_pkg::MSG_LED_SET:     msg_type = sd_link_pkg::MSG_LED_SET;
            sd_link_pkg::MSG_ECHO:        msg_type = sd_link_pkg::MSG_ECHO;
            sd_link_pkg::MSG_CMD6_STATUS: msg_type = sd_link_pkg::MSG_CMD6_STATUS;
            default:                      msg_type = sd_link_pkg::MSG_BAD;
        endcase
    end

    // ======================================================================
    // Message shift register
    // ======================================================================

    // MSB arrives first, so shift in from the bottom
    always_ff @(posedge sd_datInWrite_clk) begin
        if (state == ST_SHIFT) begin
            msg_reg <= {msg_reg[sd_link_pkg::msg_len-2:0], spi_data_in};
        end
    end

    // ======================================================================
    // Framing FSM
    // ======================================================================

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            state     <= ST_IDLE;
            bit_cnt   <= '0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;

            case (state)
                ST_IDLE: begin
                    // Leading high bit marks the frame
                    if (spi_data_in) begin
                        bit_cnt <= '0;
                        state   <= ST_SHIFT;
                    end
                end

                ST_SHIFT: begin
                    if (bit_cnt == last_bit) begin
                        bit_cnt   <= '0;
                        msg_valid <= 1'b1;  // Message complete next cycle
                        state     <= ST_WAIT;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                ST_WAIT: begin
                    if (bit_cnt == gap_last) begin
                        state <= ST_HOLD;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                ST_HOLD: begin
                    // Line is ignored until the response has gone out
                    if (!resp_busy) begin
                        state <= ST_IDLE;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/spi_resp_shift.sv ====
`default_nettype none

module spi_resp_shift #(
    parameter int turnaround_cycles = sd_link_pkg::default_turnaround
) (
    input  logic                             sd_datInWrite_clk,
    input  logic                             sd_datInWrite_rst_,
    input  logic                             resp_load,
    input  logic [sd_link_pkg::resp_len-1:0] resp_word,
    output logic                             spi_data_out,
    output logic                             spi_data_oe,
    output logic                             resp_busy
);

    // One counter times both the gap and the bit phase
    localparam int cnt_max   = (turnaround_cycles > sd_link_pkg::resp_len) ?
                               turnaround_cycles : sd_link_pkg::resp_len;
    localparam int cnt_width = $clog2(cnt_max + 1);

    localparam logic [cnt_width-1:0] gap_load  = cnt_width'(turnaround_cycles - 1);
    localparam logic [cnt_width-1:0] bits_load = cnt_width'(sd_link_pkg::resp_len - 1);

    logic [cnt_width-1:0]             cnt;
    logic                             in_gap;
    logic [sd_link_pkg::resp_len-1:0] shreg;

    // ======================================================================
    // Response shift register
    // ======================================================================

    always_ff @(posedge sd_datInWrite_clk) begin
        if (resp_load && !resp_busy) begin
            shreg <= resp_word;
        end else if (resp_busy && (!in_gap || cnt == '0)) begin
            shreg <= {shreg[sd_link_pkg::resp_len-2:0], 1'b0};
        end
    end

    // ======================================================================
    // Gap and bit timing
    // ======================================================================

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            cnt          <= '0;
            in_gap       <= 1'b0;
            resp_busy    <= 1'b0;
            spi_data_oe  <= 1'b0;
            spi_data_out <= 1'b0;
        end else if (!resp_busy) begin
            if (resp_load) begin
                resp_busy <= 1'b1;
                in_gap    <= 1'b1;
                cnt       <= gap_load;
            end
        end else if (in_gap) begin
            if (cnt == '0) begin
                // Gap over, first bit goes out
                in_gap       <= 1'b0;
                cnt          <= bits_load;
                spi_data_oe  <= 1'b1;
                spi_data_out <= shreg[sd_link_pkg::resp_len-1];
            end else begin
                cnt <= cnt - 1'b1;
            end
        end else if (cnt == '0) begin
            spi_data_oe  <= 1'b0;   // Busy drops with the enable
            spi_data_out <= 1'b0;
            resp_busy    <= 1'b0;
        end else begin
            cnt          <= cnt - 1'b1;
            spi_data_out <= shreg[sd_link_pkg::resp_len-1];
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/sd_link_pkg.sv
hw/spi_msg_decode.sv
hw/spi_cmd_execute.sv
hw/cmd6_mode_capture.sv
hw/spi_resp_shift.sv
hw/sd_link_top.sv
bench/sd_link_tb.sv
